// ==== list.f ====
src/riscboy_pkg.sv
src/uart_bit_timer.sv
src/uart_tx.sv
src/gpio.sv
src/apb_splitter.sv
src/ahbl_to_apb.sv
src/riscboy_periph.sv
sim/riscboy_periph_chk.sv
sim/tb_riscboy_periph.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_riscboy_periph -f list.f -o sim_tb \
	&& ./obj_dir/sim_tb +verilator+error+limit+1000 | tee /dev/stderr \
	| grep -q "ALL CHECKS PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== sim/riscboy_periph_chk.sv ====
// Protocol checks bound into the peripheral top level.
// Covers the two-cycle AHB-Lite error response, the APB setup/access
// order and the pad enables during reset.

`timescale 1ns/1ns

module riscboy_periph_chk (
	input logic                   clk,
	input logic                   arst_n,
	input riscboy_pkg::ahbl_rsp_t ahbl_rsp,
	input riscboy_pkg::apb_req_t  apb_req,
	input riscboy_pkg::pad_vec_t  pad_oe
);

	int assert_fails = 0;

	// ==========================================================
	// AHB-Lite error response
	// ==========================================================
	err_second_half: assert property (@(posedge clk) disable iff (!arst_n)
		(ahbl_rsp.hresp && !ahbl_rsp.hready_resp) |=> (ahbl_rsp.hresp && ahbl_rsp.hready_resp))
	else begin
		assert_fails++;
		$error("error response ended after its first cycle");
	end

	err_first_half: assert property (@(posedge clk) disable iff (!arst_n)
		(ahbl_rsp.hresp && ahbl_rsp.hready_resp) |-> $past(ahbl_rsp.hresp && !ahbl_rsp.hready_resp))
	else begin
		assert_fails++;
		$error("error response completed without a stalled first cycle");
	end

	// ==========================================================
	// APB phases and reset state
	// ==========================================================
	penable_after_setup: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
	else begin
		assert_fails++;
		$error("penable rose without a setup cycle");
	end

	oe_low_in_reset: assert property (@(posedge clk) !arst_n |-> (pad_oe == '0))
	else begin
		assert_fails++;
		$error("pad_oe not zero during reset");
	end

endmodule

// ==== sim/tb_riscboy_periph.sv ====
// Testbench for the peripheral subsystem.
// Acts as the AHB-Lite master, keeps a model of the GPIO and UART
// registers and samples the UART frame on pad 0.

`timescale 1ns/1ns

module tb_riscboy_periph;

	import riscboy_pkg::*;

	localparam int N_PADS          = 16;
	localparam int CLKS_PER_BIT    = 8;
	localparam int FRAME_CYCLES    = 10 * CLKS_PER_BIT;
	localparam int WATCHDOG_CYCLES = 40 * FRAME_CYCLES + 2000;
	localparam logic [31:0] LCG_SEED = 32'h5e9b48ff;

	localparam paddr_t ADDR_OUT  = GPIO_BASE | 16'(GPIO_OUT);
	localparam paddr_t ADDR_OE   = GPIO_BASE | 16'(GPIO_OE);
	localparam paddr_t ADDR_IN   = GPIO_BASE | 16'(GPIO_IN);
	localparam paddr_t ADDR_FSEL = GPIO_BASE | 16'(GPIO_FSEL);
	localparam paddr_t ADDR_DATA = UART_BASE | 16'(UART_DATA);
	localparam paddr_t ADDR_STAT = UART_BASE | 16'(UART_STAT);
	// Windows with no slave behind them
	localparam paddr_t ADDR_HOLE_A = 16'h2000;
	localparam paddr_t ADDR_HOLE_B = 16'hf000;

	logic      clk;
	logic      arst_n;
	logic      hready;
	ahbl_req_t ahbl_req;
	ahbl_rsp_t ahbl_rsp;
	pad_vec_t  pad_in;
	pad_vec_t  pad_out;
	pad_vec_t  pad_oe;

	int word_errs  = 0;
	int pad_errs   = 0;
	int bit_errs   = 0;
	int byte_errs  = 0;
	int other_errs = 0;

	// Register model and UART bookkeeping
	pad_vec_t    model_out;
	pad_vec_t    model_oe;
	pad_vec_t    model_in;
	pad_vec_t    model_fsel;
	logic [31:0] lcg_state;
	int unsigned cycle = 0;
	int          frames_sent = 0;
	int          frames_seen = 0;
	uart_byte_t  exp_bytes[$];
	event        frame_start;

	riscboy_periph #(
		.N_PADS       (N_PADS),
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) riscboy_periph_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.hready   (hready),
		.ahbl_req (ahbl_req),
		.ahbl_rsp (ahbl_rsp),
		.pad_in   (pad_in),
		.pad_out  (pad_out),
		.pad_oe   (pad_oe)
	);

	bind riscboy_periph riscboy_periph_chk riscboy_periph_chk_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.ahbl_rsp (ahbl_rsp),
		.apb_req  (bridge_apb_req),
		.pad_oe   (pad_oe)
	);

	always #4 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	// ==========================================================
	// Reference model and compare tasks
	// ==========================================================
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic bus_data_t ref_read(input paddr_t addr, input logic busy_exp);
		bus_data_t val;
		val = '0;
		case (addr)
			ADDR_OUT:  val[15:0] = model_out;
			ADDR_OE:   val[15:0] = model_oe;
			ADDR_IN:   val[15:0] = model_in;
			ADDR_FSEL: val[15:0] = model_fsel;
			ADDR_STAT: val[0]    = busy_exp;
			default:   val       = '0;
		endcase
		return val;
	endfunction

	// Start bit, eight data bits LSB first, stop bit
	function automatic logic ref_frame_bit(input uart_byte_t b, input int idx);
		if (idx == 0) begin
			return 1'b0;
		end
		if (idx > 8) begin
			return 1'b1;
		end
		return b[idx-1];
	endfunction

	task automatic check_word(input string name, input bus_data_t got, input bus_data_t exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
			word_errs++;
		end
	endtask

	task automatic check_pads(input string name, input pad_vec_t got, input pad_vec_t exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%04h expected 0x%04h", name, got, exp);
			pad_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			bit_errs++;
		end
	endtask

	task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%02h expected 0x%02h", name, got, exp);
			byte_errs++;
		end
	endtask

	// One stalled setup cycle, plus the first half of an error response
	task automatic check_stalls(input paddr_t addr, input int got, input logic exp_err);
		int exp_stalls;
		exp_stalls = exp_err ? 2 : 1;
		if (got != exp_stalls) begin
			$display("Data phase at address 0x%04h had %0d wait cycles instead of %0d",
				addr, got, exp_stalls);
			other_errs++;
		end
	endtask

	// ==========================================================
	// AHB-Lite master
	// ==========================================================
	task automatic bus_transfer(input paddr_t addr, input logic write, input bus_data_t wdata,
			output bus_data_t rdata, output logic err, output int stalls);
		logic prev_hresp;
		prev_hresp = 1'b0;
		stalls     = 0;
		@(posedge clk);
		ahbl_req.haddr  <= {16'h0000, addr};
		ahbl_req.hwrite <= write;
		ahbl_req.htrans <= HTRANS_NONSEQ;
		// Address phase is taken at this edge and the data phase follows
		@(posedge clk);
		ahbl_req.htrans <= 2'b00;
		ahbl_req.hwdata <= wdata;
		@(negedge clk);
		while (!ahbl_rsp.hready_resp) begin
			prev_hresp = ahbl_rsp.hresp;
			stalls++;
			@(negedge clk);
		end
		rdata = ahbl_rsp.hrdata;
		err   = ahbl_rsp.hresp;
		if (err && !prev_hresp) begin
			$display("Error response at address 0x%04h lacked its stalled first cycle", addr);
			other_errs++;
		end
	endtask

	task automatic ahb_write(input paddr_t addr, input bus_data_t data, input logic exp_err);
		bus_data_t rdata;
		logic      err;
		int        stalls;
		bus_transfer(addr, 1'b1, data, rdata, err, stalls);
		check_bit("hresp", err, exp_err);
		// UART data writes may be held off by back-pressure
		if (addr != ADDR_DATA) begin
			check_stalls(addr, stalls, exp_err);
		end
	endtask

	task automatic ahb_read(input paddr_t addr, output bus_data_t data, input logic exp_err);
		logic err;
		int   stalls;
		bus_transfer(addr, 1'b0, '0, data, err, stalls);
		check_bit("hresp", err, exp_err);
		check_stalls(addr, stalls, exp_err);
	endtask

	task automatic read_and_compare(input paddr_t addr, input logic busy_exp);
		bus_data_t rdata;
		ahb_read(addr, rdata, 1'b0);
		check_word("hrdata", rdata, ref_read(addr, busy_exp));
	endtask

	task automatic send_word(input bus_data_t data, output int unsigned done_cycle);
		ahb_write(ADDR_DATA, data, 1'b0);
		done_cycle = cycle;
		exp_bytes.push_back(data[7:0]);
		frames_sent++;
		-> frame_start;
	endtask

	// Samples pad 0 in the middle of each bit, counted from the completed write
	always begin
		uart_byte_t exp_byte;
		uart_byte_t got;
		logic       bit_val;
		@(frame_start);
		exp_byte = exp_bytes.pop_front();
		got      = '0;
		repeat (CLKS_PER_BIT / 2 + 1) @(negedge clk);
		for (int k = 0; k < 10; k++) begin
			if (k > 0) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
			end
			bit_val = pad_out[0];
			check_bit("pad_out[0]", bit_val, ref_frame_bit(exp_byte, k));
			if (k >= 1 && k <= 8) begin
				got[k-1] = bit_val;
			end
		end
		check_byte("uart frame byte", got, exp_byte);
		frames_seen++;
	end

	// ==========================================================
	// Stimulus
	// ==========================================================
	initial begin
		bus_data_t   rnd;
		bus_data_t   rdata;
		int unsigned done_a;
		int unsigned done_b;
		int          total;
		clk        = 1'b0;
		arst_n     = 1'b0;
		hready     = 1'b1;
		ahbl_req   = '0;
		pad_in     = '0;
		model_out  = '0;
		model_oe   = '0;
		model_in   = '0;
		model_fsel = '0;
		lcg_state  = LCG_SEED;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		// GPIO register round trip with FSEL bit 0 kept clear
		for (int i = 0; i < 8; i++) begin
			rnd = lcg_next();
			model_out = rnd[15:0];
			ahb_write(ADDR_OUT, rnd, 1'b0);
			rnd = lcg_next();
			model_oe = rnd[15:0];
			ahb_write(ADDR_OE, rnd, 1'b0);
			rnd = lcg_next() & 32'hffff_fffe;
			model_fsel = rnd[15:0];
			ahb_write(ADDR_FSEL, rnd, 1'b0);
			read_and_compare(ADDR_OUT, 1'b0);
			read_and_compare(ADDR_OE, 1'b0);
			read_and_compare(ADDR_FSEL, 1'b0);
			check_pads("pad_out", pad_out, model_out);
			check_pads("pad_oe", pad_oe, model_oe);
		end

		// Pad inputs through the synchronizer
		for (int i = 0; i < 4; i++) begin
			rnd = lcg_next();
			@(posedge clk);
			pad_in <= rnd[15:0];
			model_in = rnd[15:0];
			repeat (3) @(posedge clk);
			read_and_compare(ADDR_IN, 1'b0);
		end

		// Unmapped windows
		ahb_read(ADDR_HOLE_A, rdata, 1'b1);
		ahb_write(ADDR_HOLE_A, lcg_next(), 1'b1);
		ahb_read(ADDR_HOLE_B, rdata, 1'b1);
		ahb_write(ADDR_HOLE_B, lcg_next(), 1'b1);

		// Single UART frame on pad 0
		model_fsel = 16'h0001;
		ahb_write(ADDR_FSEL, 32'h0000_0001, 1'b0);
		send_word(lcg_next(), done_a);
		wait (frames_seen == frames_sent);
		repeat (CLKS_PER_BIT) @(posedge clk);
		read_and_compare(ADDR_STAT, 1'b0);

		// Back-to-back frames where pready holds off the second write
		send_word(lcg_next(), done_a);
		read_and_compare(ADDR_STAT, 1'b1);
		send_word(lcg_next(), done_b);
		if (done_b - done_a <= FRAME_CYCLES) begin
			$display("Second UART write completed while the first frame was still busy");
			other_errs++;
		end
		read_and_compare(ADDR_STAT, 1'b1);
		wait (frames_seen == frames_sent);
		repeat (CLKS_PER_BIT) @(posedge clk);
		read_and_compare(ADDR_STAT, 1'b0);

		total = word_errs + pad_errs + bit_errs + byte_errs + other_errs
			+ riscboy_periph_inst.riscboy_periph_chk_inst.assert_fails;
		$display("Errors: word %0d, pads %0d, bit %0d, byte %0d, other %0d, assertion %0d",
			word_errs, pad_errs, bit_errs, byte_errs, other_errs,
			riscboy_periph_inst.riscboy_periph_chk_inst.assert_fails);
		if (total == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== src/ahbl_to_apb.sv ====
// AHB-Lite slave to APB master bridge.
// Each accepted AHB-Lite transfer becomes exactly one APB transfer.
// No pipelining, so the data phase of one transfer always finishes
// before the next APB setup cycle starts.

`timescale 1ns/1ns

module ahbl_to_apb (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   hready,
	input  riscboy_pkg::ahbl_req_t ahbl_req,
	output riscboy_pkg::ahbl_rsp_t ahbl_rsp,
	output riscboy_pkg::apb_req_t  apb_req,
	input  riscboy_pkg::apb_rsp_t  apb_rsp
);

	import riscboy_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS,
		ST_ERR2
	} bridge_state_t;

	bridge_state_t state;
	bridge_state_t state_nxt;

	paddr_t    paddr_q;
	logic      pwrite_q;
	bus_data_t hrdata_q;

	logic hready_resp;
	logic accept;
	logic access_done;

	// ==========================================================
	// AHB-Lite side
	// ==========================================================

	// Access cycle that the slave has finished
	assign access_done = (state == ST_ACCESS) && apb_rsp.pready;

	always_comb begin
		case (state)
			ST_SETUP:  hready_resp = 1'b0;
			// First half of an error response keeps the bus stalled
			ST_ACCESS: hready_resp = apb_rsp.pready && !apb_rsp.pslverr;
			default:   hready_resp = 1'b1;
		endcase
	end

	assign accept = hready && (ahbl_req.htrans == HTRANS_NONSEQ) && hready_resp;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_SETUP:  state_nxt = ST_ACCESS;
			ST_ACCESS: begin
				if (apb_rsp.pready) begin
					state_nxt = apb_rsp.pslverr ? ST_ERR2 : ST_IDLE;
				end
			end
			default:   state_nxt = ST_IDLE;
		endcase
		// A new address phase may overlap the last data cycle
		if (accept) begin
			state_nxt = ST_SETUP;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Address phase capture
	always_ff @(posedge clk) begin
		if (accept) begin
			paddr_q  <= ahbl_req.haddr[$bits(paddr_t)-1:0];
			pwrite_q <= ahbl_req.hwrite;
		end
	end

	// Read data held after the access cycle
	always_ff @(posedge clk) begin
		if (access_done) begin
			hrdata_q <= apb_rsp.prdata;
		end
	end

	always_comb begin
		ahbl_rsp.hready_resp = hready_resp;
		ahbl_rsp.hresp       = (state == ST_ERR2) || (access_done && apb_rsp.pslverr);
		// Pass prdata through during the access and the held copy after it
		ahbl_rsp.hrdata      = (state == ST_ACCESS) ? apb_rsp.prdata : hrdata_q;
	end

	// ==========================================================
	// APB side
	// ==========================================================
	always_comb begin
		apb_req.paddr   = paddr_q;
		apb_req.psel    = (state == ST_SETUP) || (state == ST_ACCESS);
		apb_req.penable = (state == ST_ACCESS);
		apb_req.pwrite  = pwrite_q;
		// hwdata is stable for the whole data phase
		apb_req.pwdata  = ahbl_req.hwdata;
	end

endmodule

// ==== src/apb_splitter.sv ====
// APB address decoder.
// Routes the bridge's transfer to GPIO or UART by paddr[15:12] and
// returns the selected slave's response. Unmapped windows get a
// slave error in the access cycle.

`timescale 1ns/1ns

module apb_splitter (
	input  riscboy_pkg::apb_req_t bridge_req,
	output riscboy_pkg::apb_rsp_t bridge_rsp,
	output riscboy_pkg::apb_req_t gpio_req,
	input  riscboy_pkg::apb_rsp_t gpio_rsp,
	output riscboy_pkg::apb_req_t uart_req,
	input  riscboy_pkg::apb_rsp_t uart_rsp
);

	import riscboy_pkg::*;

	logic sel_gpio;
	logic sel_uart;

	assign sel_gpio = bridge_req.paddr[15:12] == GPIO_BASE[15:12];
	assign sel_uart = bridge_req.paddr[15:12] == UART_BASE[15:12];

	// Full request goes to both slaves with psel only on the decoded one
	always_comb begin
		gpio_req      = bridge_req;
		gpio_req.psel = bridge_req.psel && sel_gpio;
		uart_req      = bridge_req;
		uart_req.psel = bridge_req.psel && sel_uart;
	end

	// Response mux
	always_comb begin
		if (sel_gpio) begin
			bridge_rsp = gpio_rsp;
		end else if (sel_uart) begin
			bridge_rsp = uart_rsp;
		end else begin
			// Unmapped window completes at once with an error
			bridge_rsp.pready  = 1'b1;
			bridge_rsp.prdata  = '0;
			bridge_rsp.pslverr = bridge_req.psel && bridge_req.penable;
		end
	end

endmodule

// ==== src/gpio.sv ====
// GPIO block with APB registers and simple pad muxing.
// OUT and OE drive the pads directly; FSEL bit 0 hands pad 0 to the
// UART transmitter. IN reads the pads through a two-flop synchronizer.

`timescale 1ns/1ns

module gpio #(
	parameter int N_PADS = 16
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  riscboy_pkg::apb_req_t apb_req,
	output riscboy_pkg::apb_rsp_t apb_rsp,
	input  riscboy_pkg::pad_vec_t pad_in,
	input  logic                  uart_txd,
	output riscboy_pkg::pad_vec_t pad_out,
	output riscboy_pkg::pad_vec_t pad_oe
);

	import riscboy_pkg::*;

	logic [N_PADS-1:0] out_q;
	logic [N_PADS-1:0] oe_q;
	logic [N_PADS-1:0] fsel_q;
	logic [N_PADS-1:0] in_meta_q;
	logic [N_PADS-1:0] in_sync_q;
	logic              wr_en;
	logic [11:0]       offset;

	assign offset = apb_req.paddr[11:0];
	assign wr_en  = apb_req.psel && apb_req.penable && apb_req.pwrite;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_q     <= '0;
			oe_q      <= '0;
			fsel_q    <= '0;
			in_meta_q <= '0;
			in_sync_q <= '0;
		end else begin
			in_meta_q <= pad_in[N_PADS-1:0];
			in_sync_q <= in_meta_q;
			if (wr_en) begin
				case (offset)
					GPIO_OUT:  out_q  <= apb_req.pwdata[N_PADS-1:0];
					GPIO_OE:   oe_q   <= apb_req.pwdata[N_PADS-1:0];
					GPIO_FSEL: fsel_q <= apb_req.pwdata[N_PADS-1:0];
					default:   ;
				endcase
			end
		end
	end

	// No wait states, no errors
	always_comb begin
		apb_rsp.pready  = 1'b1;
		apb_rsp.pslverr = 1'b0;
		apb_rsp.prdata  = '0;
		case (offset)
			GPIO_OUT:  apb_rsp.prdata[N_PADS-1:0] = out_q;
			GPIO_OE:   apb_rsp.prdata[N_PADS-1:0] = oe_q;
			GPIO_IN:   apb_rsp.prdata[N_PADS-1:0] = in_sync_q;
			GPIO_FSEL: apb_rsp.prdata[N_PADS-1:0] = fsel_q;
			default:   ;
		endcase
	end

	// Pad mux
	always_comb begin
		pad_out             = '0;
		pad_oe              = '0;
		pad_out[N_PADS-1:0] = out_q;
		pad_oe[N_PADS-1:0]  = oe_q;
		if (fsel_q[0]) begin
			pad_out[0] = uart_txd;
		end
	end

endmodule

// ==== src/riscboy_periph.sv ====
// Peripheral subsystem top level.
// AHB-Lite slave port in, APB fabric inside, UART and GPIO behind it.
// Only instances and the nets between them live here.

`timescale 1ns/1ns

module riscboy_periph #(
	parameter int N_PADS       = 16,
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   hready,
	input  riscboy_pkg::ahbl_req_t ahbl_req,
	output riscboy_pkg::ahbl_rsp_t ahbl_rsp,
	input  riscboy_pkg::pad_vec_t  pad_in,
	output riscboy_pkg::pad_vec_t  pad_out,
	output riscboy_pkg::pad_vec_t  pad_oe
);

	import riscboy_pkg::*;

	// ==========================================================
	// Interconnect
	// ==========================================================
	apb_req_t bridge_apb_req;
	apb_rsp_t bridge_apb_rsp;
	apb_req_t gpio_apb_req;
	apb_rsp_t gpio_apb_rsp;
	apb_req_t uart_apb_req;
	apb_rsp_t uart_apb_rsp;
	logic     uart_txd;

	// ==========================================================
	// Bus fabric
	// ==========================================================
	ahbl_to_apb ahbl_to_apb_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.hready   (hready),
		.ahbl_req (ahbl_req),
		.ahbl_rsp (ahbl_rsp),
		.apb_req  (bridge_apb_req),
		.apb_rsp  (bridge_apb_rsp)
	);

	apb_splitter apb_splitter_inst (
		.bridge_req (bridge_apb_req),
		.bridge_rsp (bridge_apb_rsp),
		.gpio_req   (gpio_apb_req),
		.gpio_rsp   (gpio_apb_rsp),
		.uart_req   (uart_apb_req),
		.uart_rsp   (uart_apb_rsp)
	);

	// ==========================================================
	// Slaves
	// ==========================================================
	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) uart_tx_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.apb_req (uart_apb_req),
		.apb_rsp (uart_apb_rsp),
		.txd     (uart_txd)
	);

	gpio #(
		.N_PADS (N_PADS)
	) gpio_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.apb_req  (gpio_apb_req),
		.apb_rsp  (gpio_apb_rsp),
		.pad_in   (pad_in),
		.uart_txd (uart_txd),
		.pad_out  (pad_out),
		.pad_oe   (pad_oe)
	);

endmodule

// ==== src/riscboy_pkg.sv ====
// Shared definitions for the peripheral subsystem.
// Holds the bus structs, the width typedefs, the APB address map
// and the register offsets. Modules import it inside their body.

package riscboy_pkg;

	// ==========================================================
	// Widths
	// ==========================================================
	typedef logic [31:0] haddr_t;
	typedef logic [15:0] paddr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [15:0] pad_vec_t;
	typedef logic [7:0]  uart_byte_t;

	// ==========================================================
	// Bus structs
	// ==========================================================
	typedef struct packed {
		haddr_t    haddr;
		logic      hwrite;
		logic [1:0] htrans;
		bus_data_t hwdata;
	} ahbl_req_t;

	typedef struct packed {
		logic      hready_resp;
		logic      hresp;
		bus_data_t hrdata;
	} ahbl_rsp_t;

	typedef struct packed {
		paddr_t    paddr;
		logic      psel;
		logic      penable;
		logic      pwrite;
		bus_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		logic      pready;
		bus_data_t prdata;
		logic      pslverr;
	} apb_rsp_t;

	// AHB transfer type
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

	// Slave windows, decoded on paddr[15:12]
	localparam paddr_t GPIO_BASE = 16'h0000;
	localparam paddr_t UART_BASE = 16'h1000;

	// Register offsets inside a window
	localparam logic [11:0] GPIO_OUT  = 12'h000;
	localparam logic [11:0] GPIO_OE   = 12'h004;
	localparam logic [11:0] GPIO_IN   = 12'h008;
	localparam logic [11:0] GPIO_FSEL = 12'h00c;
	localparam logic [11:0] UART_DATA = 12'h000;
	// Bit 0 is busy
	localparam logic [11:0] UART_STAT = 12'h004;

endpackage

// ==== src/uart_bit_timer.sv ====
// Bit timer for the UART transmitter.
// A start pulse begins a ten-bit frame; bit_tick marks the last clock
// of each bit and busy covers the frame up to the end of the stop bit.

`timescale 1ns/1ns

module uart_bit_timer #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       start,
	output logic       bit_tick,
	output logic [3:0] bit_index,
	output logic       busy
);

	localparam int W_DIV = $clog2(CLKS_PER_BIT + 1);
	localparam logic [W_DIV-1:0] DIV_LAST = W_DIV'(CLKS_PER_BIT - 1);
	// Start, 8 data, stop
	localparam logic [3:0] LAST_BIT = 4'd9;

	logic [W_DIV-1:0] div_q;

	assign bit_tick = busy && (div_q == DIV_LAST);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_q     <= '0;
			bit_index <= '0;
			busy      <= 1'b0;
		end else if (start) begin
			div_q     <= '0;
			bit_index <= '0;
			busy      <= 1'b1;
		end else if (bit_tick) begin
			div_q     <= '0;
			bit_index <= bit_index + 4'd1;
			if (bit_index == LAST_BIT) begin
				busy <= 1'b0;
			end
		end else if (busy) begin
			div_q <= div_q + W_DIV'(1);
		end
	end

endmodule

// ==== src/uart_tx.sv ====
// UART transmitter with an APB register interface.
// A write to DATA sends one 8N1 frame; while a frame is in progress
// a further DATA write is held off with pready low. STAT bit 0 is busy.

`timescale 1ns/1ns

module uart_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  riscboy_pkg::apb_req_t apb_req,
	output riscboy_pkg::apb_rsp_t apb_rsp,
	output logic                  txd
);

	import riscboy_pkg::*;

	logic       apb_access;
	logic       data_wr;
	logic       stall;
	logic       start;
	logic       bit_tick;
	logic [3:0] bit_index;
	logic       busy;
	logic       frame_end;
	uart_byte_t tx_byte;
	logic [9:0] frame_q;

	// ==========================================================
	// Register decode
	// ==========================================================
	assign apb_access = apb_req.psel && apb_req.penable;
	assign data_wr    = apb_access && apb_req.pwrite && (apb_req.paddr[11:0] == UART_DATA);

	// Back-pressure until the current frame has drained
	assign stall = data_wr && busy;
	assign start = data_wr && !busy;

	assign tx_byte = apb_req.pwdata[7:0];

	always_comb begin
		apb_rsp.pready  = !stall;
		apb_rsp.pslverr = 1'b0;
		apb_rsp.prdata  = '0;
		if (apb_req.paddr[11:0] == UART_STAT) begin
			apb_rsp.prdata[0] = busy;
		end
	end

	// ==========================================================
	// Frame shifter
	// ==========================================================
	uart_bit_timer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) uart_bit_timer_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start),
		.bit_tick  (bit_tick),
		.bit_index (bit_index),
		.busy      (busy)
	);

	assign frame_end = bit_tick && (bit_index == 4'd9);

	// LSB goes out first and the line idles high
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			frame_q <= '1;
		end else if (start) begin
			frame_q <= {1'b1, tx_byte, 1'b0};
		end else if (frame_end) begin
			frame_q <= '1;
		end else if (bit_tick) begin
			frame_q <= {1'b1, frame_q[9:1]};
		end
	end

	assign txd = frame_q[0];

endmodule
